// ==== hdl/rv_exec_pkg.sv ====
package rv_exec_pkg;

    // Widths that carry a meaning across the engine
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  axil_addr_t;
    typedef logic [15:0] retire_cnt_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_t;

    // Integer funct3, shared by the register and immediate forms
    typedef enum logic [2:0] {
        ADDSUB = 3'b000,
        SLL    = 3'b001,
        SLT    = 3'b010,
        SLTU   = 3'b011,
        XOR    = 3'b100,
        SR     = 3'b101,
        OR     = 3'b110,
        AND    = 3'b111
    } funct3_alu_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    // Operand and writeback selects
    typedef enum logic {A_RS1, A_PC} a_sel_t;
    typedef enum logic {B_RS2, B_IMM} b_sel_t;
    typedef enum logic [1:0] {W_ALU = 2'd0, W_UIMM = 2'd1} w_sel_t;

endpackage

// ==== hdl/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if;
    import rv_exec_pkg::*;

    word_t    instr;
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    a_sel_t   a_sel;
    b_sel_t   b_sel;
    w_sel_t   w_sel;
    alu_op_t  alu_op;
    logic     wen;
    logic     illegal;

    modport decoder (
        input  instr,
        output opcode, rd, rs1, rs2, imm, a_sel, b_sel, w_sel, alu_op, wen, illegal
    );

    // Datapath owns the instruction register
    modport datapath (
        output instr,
        input  rd, rs1, rs2, imm, a_sel, b_sel, w_sel, alu_op, wen, illegal
    );

endinterface

// ==== hdl/issue_if.sv ====
`timescale 1ns/1ps

interface issue_if;
    import rv_exec_pkg::*;

    // Host to engine
    logic        issue;
    word_t       instr;
    reg_idx_t    win_idx;

    // Engine to host
    logic        done;
    logic        fault;
    word_t       pc;
    retire_cnt_t retire_cnt;
    logic        busy;
    word_t       win_data;

    modport host (
        output issue, instr, win_idx,
        input  done, fault, pc, retire_cnt, busy, win_data
    );

    modport exec (
        input  issue, instr, win_idx,
        output done, fault, pc, retire_cnt, busy, win_data
    );

endinterface

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    decode_if.decoder dec_if
);
    import rv_exec_pkg::*;

    funct3_alu_t funct3;
    logic [6:0]  funct7;
    word_t       imm_i;
    word_t       imm_u;
    logic        alt;
    logic        alu_form;

    // Instruction fields
    assign dec_if.opcode = opcode_t'(dec_if.instr[6:0]);
    assign dec_if.rd     = dec_if.instr[11:7];
    assign dec_if.rs1    = dec_if.instr[19:15];
    assign dec_if.rs2    = dec_if.instr[24:20];
    assign funct3        = funct3_alu_t'(dec_if.instr[14:12]);
    assign funct7        = dec_if.instr[31:25];
    assign alt           = dec_if.instr[30];

    assign imm_i = {{20{dec_if.instr[31]}}, dec_if.instr[31:20]};
    assign imm_u = {dec_if.instr[31:12], 12'b0};

    // U-type only for LUI and AUIPC, shifts use imm[4:0] as shamt
    assign dec_if.imm = (dec_if.opcode == LUI || dec_if.opcode == AUIPC) ? imm_u : imm_i;

    assign dec_if.a_sel = (dec_if.opcode == AUIPC) ? A_PC : A_RS1;
    assign dec_if.b_sel = (dec_if.opcode == REGREG) ? B_RS2 : B_IMM;
    assign dec_if.w_sel = (dec_if.opcode == LUI) ? W_UIMM : W_ALU;

    always_comb begin
        case (dec_if.opcode)
            REGREG, IMMED, LUI, AUIPC: dec_if.wen = 1'b1;
            default:                   dec_if.wen = 1'b0;
        endcase
    end

    assign alu_form = (dec_if.opcode == REGREG) || (dec_if.opcode == IMMED);

    // ALU operation from funct3 and bit 30
    always_comb begin
        dec_if.alu_op = ALU_ADD;
        if (alu_form) begin
            case (funct3)
                ADDSUB: begin
                    if (dec_if.opcode == REGREG && alt) dec_if.alu_op = ALU_SUB;
                    else dec_if.alu_op = ALU_ADD;
                end
                SLL:     dec_if.alu_op = ALU_SLL;
                SLT:     dec_if.alu_op = ALU_SLT;
                SLTU:    dec_if.alu_op = ALU_SLTU;
                XOR:     dec_if.alu_op = ALU_XOR;
                SR:      dec_if.alu_op = alt ? ALU_SRA : ALU_SRL;
                OR:      dec_if.alu_op = ALU_OR;
                AND:     dec_if.alu_op = ALU_AND;
                default: dec_if.alu_op = ALU_ADD;
            endcase
        end
    end

    // Known opcodes are legal, REGREG only with funct7 zero or 0x20
    always_comb begin
        case (dec_if.opcode)
            REGREG:
                dec_if.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
            LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, IMMED, MISCMEM, SYSTEM:
                dec_if.illegal = 1'b0;
            default:
                dec_if.illegal = 1'b1;
        endcase
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 we_i,
    input  rv_exec_pkg::reg_idx_t waddr_i,
    input  rv_exec_pkg::word_t    wdata_i,
    input  rv_exec_pkg::reg_idx_t raddr_a_i,
    input  rv_exec_pkg::reg_idx_t raddr_b_i,
    input  rv_exec_pkg::reg_idx_t raddr_win_i,
    output rv_exec_pkg::word_t    rdata_a_o,
    output rv_exec_pkg::word_t    rdata_b_o,
    output rv_exec_pkg::word_t    rdata_win_o
);
    import rv_exec_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata_a_o   = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
        rdata_b_o   = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];
        rdata_win_o = (raddr_win_i == '0) ? '0 : regs[raddr_win_i];
    end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_exec_pkg::alu_op_t op_i,
    input  rv_exec_pkg::word_t   a_i,
    input  rv_exec_pkg::word_t   b_i,
    output rv_exec_pkg::word_t   result_o
);
    import rv_exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: result_o = {31'b0, a_i < b_i};
            default:  result_o = '0;
        endcase
    end

endmodule

// ==== hdl/exec_datapath.sv ====
`timescale 1ns/1ps

module exec_datapath #(
    parameter rv_exec_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input logic        clk,
    input logic        reset_i,
    issue_if.exec      iss_if,
    decode_if.datapath dec_if
);
    import rv_exec_pkg::*;

    typedef enum logic {IDLE, EXEC} exec_state_t;

    exec_state_t state;
    word_t       instr_q;
    word_t       pc_q;
    retire_cnt_t retire_q;
    logic        done_q;
    logic        fault_q;
    logic        exec_ok;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       alu_a;
    word_t       alu_b;
    word_t       alu_result;
    word_t       wb_data;

    // Only legal REGREG, IMMED, LUI and AUIPC retire
    assign exec_ok = dec_if.wen && !dec_if.illegal;

    always_ff @(posedge clk) begin
        if (state == IDLE && iss_if.issue) instr_q <= iss_if.instr;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state    <= IDLE;
            pc_q     <= RESET_PC;
            retire_q <= '0;
            done_q   <= 1'b0;
            fault_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: if (iss_if.issue) state <= EXEC;
                EXEC: begin
                    state   <= IDLE;
                    done_q  <= 1'b1;
                    fault_q <= !exec_ok;
                    if (exec_ok) begin
                        pc_q     <= pc_q + 32'd4;
                        retire_q <= retire_q + 16'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign alu_a   = (dec_if.a_sel == A_PC) ? pc_q : rs1_data;
    assign alu_b   = (dec_if.b_sel == B_IMM) ? dec_if.imm : rs2_data;
    assign wb_data = (dec_if.w_sel == W_UIMM) ? dec_if.imm : alu_result;

    reg_file u_reg_file (
        .clk         (clk),
        .reset_i     (reset_i),
        .we_i        (state == EXEC && exec_ok),
        .waddr_i     (dec_if.rd),
        .wdata_i     (wb_data),
        .raddr_a_i   (dec_if.rs1),
        .raddr_b_i   (dec_if.rs2),
        .raddr_win_i (iss_if.win_idx),
        .rdata_a_o   (rs1_data),
        .rdata_b_o   (rs2_data),
        .rdata_win_o (iss_if.win_data)
    );

    alu u_alu (
        .op_i     (dec_if.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    assign dec_if.instr      = instr_q;
    assign iss_if.done       = done_q;
    assign iss_if.fault      = fault_q;
    assign iss_if.pc         = pc_q;
    assign iss_if.retire_cnt = retire_q;
    assign iss_if.busy       = (state != IDLE);

endmodule

// ==== hdl/axil_host_regs.sv ====
`timescale 1ns/1ps

module axil_host_regs (
    input  logic                   clk,
    input  logic                   reset_i,
    input  rv_exec_pkg::axil_addr_t s_awaddr_i,
    input  logic                   s_awvalid_i,
    output logic                   s_awready_o,
    input  rv_exec_pkg::word_t      s_wdata_i,
    input  logic [3:0]             s_wstrb_i,
    input  logic                   s_wvalid_i,
    output logic                   s_wready_o,
    output logic [1:0]             s_bresp_o,
    output logic                   s_bvalid_o,
    input  logic                   s_bready_i,
    input  rv_exec_pkg::axil_addr_t s_araddr_i,
    input  logic                   s_arvalid_i,
    output logic                   s_arready_o,
    output rv_exec_pkg::word_t      s_rdata_o,
    output logic [1:0]             s_rresp_o,
    output logic                   s_rvalid_o,
    input  logic                   s_rready_i,
    issue_if.host                  iss_if
);
    import rv_exec_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_EXEC, W_RESP} wr_state_t;

    // Register map
    localparam axil_addr_t ADDR_CMD    = 8'h00;
    localparam axil_addr_t ADDR_PC     = 8'h04;
    localparam axil_addr_t ADDR_RETIRE = 8'h08;
    localparam axil_addr_t ADDR_WIN    = 8'h80;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    wr_state_t  wr_state;
    logic       wr_ready_q;
    logic       wr_accept;
    logic       cmd_write;
    logic       issue_q;
    word_t      cmd_q;
    logic       bvalid_q;
    logic [1:0] bresp_q;
    logic       ar_ready_q;
    logic       rd_accept;
    logic       rvalid_q;
    word_t      rdata_q;
    word_t      rd_mux;

    assign wr_accept = wr_ready_q && s_awvalid_i && s_wvalid_i;
    // Full-word write to the command register
    assign cmd_write = (s_awaddr_i == ADDR_CMD) && (s_wstrb_i == 4'hF);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_state   <= W_IDLE;
            wr_ready_q <= 1'b0;
            issue_q    <= 1'b0;
            bvalid_q   <= 1'b0;
            cmd_q      <= '0;
        end else begin
            wr_ready_q <= 1'b0;
            issue_q    <= 1'b0;
            case (wr_state)
                W_IDLE: begin
                    if (wr_accept) begin
                        if (cmd_write) begin
                            issue_q  <= 1'b1;
                            cmd_q    <= s_wdata_i;
                            wr_state <= W_EXEC;
                        end else begin
                            bvalid_q <= 1'b1;
                            wr_state <= W_RESP;
                        end
                    end else if (s_awvalid_i && s_wvalid_i && !wr_ready_q && !iss_if.busy) begin
                        wr_ready_q <= 1'b1;
                    end
                end
                W_EXEC: begin
                    // Answer on the cycle after done
                    if (iss_if.done) begin
                        bvalid_q <= 1'b1;
                        wr_state <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (s_bready_i) begin
                        bvalid_q <= 1'b0;
                        wr_state <= W_IDLE;
                    end
                end
                default: wr_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_state == W_IDLE && wr_accept) begin
            // Partial strobe on the command register fails without issue
            bresp_q <= (s_awaddr_i == ADDR_CMD) ? RESP_SLVERR : RESP_OKAY;
        end else if (wr_state == W_EXEC && iss_if.done) begin
            bresp_q <= iss_if.fault ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assign rd_accept = ar_ready_q && s_arvalid_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ar_ready_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            ar_ready_q <= 1'b0;
            if (rd_accept) begin
                rvalid_q <= 1'b1;
            end else if (s_arvalid_i && !rvalid_q && !ar_ready_q) begin
                ar_ready_q <= 1'b1;
            end
            if (rvalid_q && s_rready_i) rvalid_q <= 1'b0;
        end
    end

    // Register window indexed straight from the read address
    assign iss_if.win_idx = s_araddr_i[6:2];

    always_comb begin
        if (s_araddr_i >= ADDR_WIN) begin
            rd_mux = iss_if.win_data;
        end else begin
            case (s_araddr_i)
                ADDR_CMD:    rd_mux = cmd_q;
                ADDR_PC:     rd_mux = iss_if.pc;
                ADDR_RETIRE: rd_mux = word_t'(iss_if.retire_cnt);
                default:     rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) rdata_q <= rd_mux;
    end

    assign iss_if.issue = issue_q;
    assign iss_if.instr = cmd_q;
    assign s_awready_o  = wr_ready_q;
    assign s_wready_o   = wr_ready_q;
    assign s_bvalid_o   = bvalid_q;
    assign s_bresp_o    = bresp_q;
    assign s_arready_o  = ar_ready_q;
    assign s_rvalid_o   = rvalid_q;
    assign s_rdata_o    = rdata_q;
    assign s_rresp_o    = RESP_OKAY;

endmodule

// ==== hdl/rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top #(
    parameter rv_exec_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  rv_exec_pkg::axil_addr_t s_awaddr_i,
    input  logic                   s_awvalid_i,
    output logic                   s_awready_o,
    input  rv_exec_pkg::word_t      s_wdata_i,
    input  logic [3:0]             s_wstrb_i,
    input  logic                   s_wvalid_i,
    output logic                   s_wready_o,
    output logic [1:0]             s_bresp_o,
    output logic                   s_bvalid_o,
    input  logic                   s_bready_i,
    input  rv_exec_pkg::axil_addr_t s_araddr_i,
    input  logic                   s_arvalid_i,
    output logic                   s_arready_o,
    output rv_exec_pkg::word_t      s_rdata_o,
    output logic [1:0]             s_rresp_o,
    output logic                   s_rvalid_o,
    input  logic                   s_rready_i
);

    decode_if dec_if ();
    issue_if  iss_if ();

    axil_host_regs u_host (
        .clk         (clk),
        .reset_i     (reset_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .iss_if      (iss_if.host)
    );

    exec_datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk     (clk),
        .reset_i (reset_i),
        .iss_if  (iss_if.exec),
        .dec_if  (dec_if.datapath)
    );

    control_unit u_control (
        .dec_if (dec_if.decoder)
    );

endmodule

// ==== bench/rv_exec_sva.sv ====
`timescale 1ns/1ps

module axil_host_sva (
    input logic               clk_i,
    input logic               reset_i,
    input logic               bvalid_i,
    input logic               bready_i,
    input logic [1:0]         bresp_i,
    input logic               rvalid_i,
    input logic               rready_i,
    input rv_exec_pkg::word_t rdata_i,
    input logic               done_i,
    input logic               issue_i,
    input logic               busy_i
);

    // Number of failed assertions
    int fail_count = 0;

    // Write response held with its value until the host takes it
    property bresp_held;
        @(posedge clk_i) disable iff (reset_i)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i);
    endproperty

    property rdata_held;
        @(posedge clk_i) disable iff (reset_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i);
    endproperty

    property done_then_bvalid;
        @(posedge clk_i) disable iff (reset_i)
        done_i |=> bvalid_i;
    endproperty

    property no_issue_when_busy;
        @(posedge clk_i) disable iff (reset_i)
        issue_i |-> !busy_i;
    endproperty

    a_bresp_held: assert property (bresp_held) else begin
        $error("write response changed before bready");
        fail_count++;
    end

    a_rdata_held: assert property (rdata_held) else begin
        $error("read data changed before rready");
        fail_count++;
    end

    a_done_then_bvalid: assert property (done_then_bvalid) else begin
        $error("bvalid did not follow done");
        fail_count++;
    end

    a_no_issue_when_busy: assert property (no_issue_when_busy) else begin
        $error("issue raised while the engine was busy");
        fail_count++;
    end

endmodule

bind axil_host_regs axil_host_sva u_sva (
    .clk_i    (clk),
    .reset_i  (reset_i),
    .bvalid_i (s_bvalid_o),
    .bready_i (s_bready_i),
    .bresp_i  (s_bresp_o),
    .rvalid_i (s_rvalid_o),
    .rready_i (s_rready_i),
    .rdata_i  (s_rdata_o),
    .done_i   (iss_if.done),
    .issue_i  (iss_if.issue),
    .busy_i   (iss_if.busy)
);

// ==== bench/rv_exec_tb.sv ====
`timescale 1ns/1ps

module rv_exec_tb;
    import rv_exec_pkg::*;

    localparam int    CLK_PERIOD = 40;
    localparam word_t RESET_PC   = 32'h0000_1000;
    localparam int    N_ALU      = 200;
    // Reset reads, ALU stream, U-type, unsupported, back-pressure, strobe
    localparam int    N_TRANS    = 34 + 3 * N_ALU + 40 + 24 + 32 + 3;

    localparam axil_addr_t ADDR_CMD    = 8'h00;
    localparam axil_addr_t ADDR_PC     = 8'h04;
    localparam axil_addr_t ADDR_RETIRE = 8'h08;
    localparam logic [1:0] OKAY        = 2'b00;
    localparam logic [1:0] SLVERR      = 2'b10;

    // LOAD, STORE, BRANCH, JAL, SYSTEM and one undefined opcode
    localparam logic [6:0] BAD_OPS [6] = '{7'h03, 7'h23, 7'h63, 7'h6F, 7'h73, 7'h7F};

    logic       clk;
    logic       reset_i;
    axil_addr_t s_awaddr_i;
    logic       s_awvalid_i;
    logic       s_awready_o;
    word_t      s_wdata_i;
    logic [3:0] s_wstrb_i;
    logic       s_wvalid_i;
    logic       s_wready_o;
    logic [1:0] s_bresp_o;
    logic       s_bvalid_o;
    logic       s_bready_i;
    axil_addr_t s_araddr_i;
    logic       s_arvalid_i;
    logic       s_arready_o;
    word_t      s_rdata_o;
    logic [1:0] s_rresp_o;
    logic       s_rvalid_o;
    logic       s_rready_i;

    word_t       model_regs [0:31];
    word_t       model_pc;
    retire_cnt_t model_retire;
    word_t       rng_state = 32'd45;

    rv_exec_top #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((N_TRANS * 20 + 10) * CLK_PERIOD);
        $display("timeout: the AXI4-Lite transactions did not complete in time");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    // Stop at the first failed bound assertion
    initial begin
        wait (dut.u_host.u_sva.fail_count != 0);
        $display("Simulation finished: FAIL");
        $fatal(1, "a concurrent assertion on the AXI4-Lite host block failed");
    end

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // RV32I integer result by funct3, alt selects SUB and SRA
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(input word_t instr, output logic [1:0] resp);
        logic [6:0] f7;
        logic [2:0] f3;
        reg_idx_t   rd;
        word_t      a;
        word_t      imm_u;
        word_t      result;
        logic       ok;
        f7     = instr[31:25];
        f3     = instr[14:12];
        rd     = instr[11:7];
        a      = model_regs[instr[19:15]];
        imm_u  = {instr[31:12], 12'h000};
        ok     = 1'b1;
        result = '0;
        case (instr[6:0])
            7'h33: begin
                if (f7 == 7'h00 || f7 == 7'h20) begin
                    result = alu_ref(f3, f7[5], a, model_regs[instr[24:20]]);
                end else begin
                    ok = 1'b0;
                end
            end
            7'h13:   result = alu_ref(f3, (f3 == 3'd5) && instr[30], a,
                                      {{20{instr[31]}}, instr[31:20]});
            7'h37:   result = imm_u;
            7'h17:   result = model_pc + imm_u;
            default: ok = 1'b0;
        endcase
        if (ok) begin
            if (rd != 5'd0) model_regs[rd] = result;
            model_pc     = model_pc + 32'd4;
            model_retire = model_retire + 16'd1;
            resp         = OKAY;
        end else begin
            resp = SLVERR;
        end
    endtask

    // REGREG or IMMED with random fields, shifts keep valid upper bits
    task automatic random_alu_instr(output word_t instr);
        word_t      r;
        word_t      r2;
        logic [2:0] f3;
        logic [11:0] imm;
        r  = rand_word();
        r2 = rand_word();
        f3 = r[2:0];
        if (r[18]) begin
            instr = {((f3 == 3'd0 || f3 == 3'd5) && r[19]) ? 7'h20 : 7'h00,
                     r[17:13], r[12:8], f3, r[7:3], 7'h33};
        end else begin
            imm = r2[11:0];
            if (f3 == 3'd1) imm[11:5] = 7'h00;
            else if (f3 == 3'd5) imm[11:5] = r[19] ? 7'h20 : 7'h00;
            instr = {imm, r[12:8], f3, r[7:3], 7'h13};
        end
    endtask

    task tick();
        @(posedge clk);
        #2;
    endtask

    task automatic expect_equal(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic drive_write(input axil_addr_t addr, input word_t data, input logic [3:0] strb);
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_wstrb_i   = strb;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
    endtask

    task automatic await_write_accept();
        while (!s_awready_o) tick();
        expect_equal("s_wready_o", word_t'(s_wready_o), 32'd1);
        tick();
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
    endtask

    // No new write may be accepted while a response is pending
    task automatic collect_response(input int hold, output logic [1:0] resp);
        while (!s_bvalid_o) begin
            expect_equal("s_awready_o", word_t'(s_awready_o), 32'd0);
            expect_equal("s_wready_o", word_t'(s_wready_o), 32'd0);
            tick();
        end
        resp = s_bresp_o;
        repeat (hold) begin
            tick();
            expect_equal("s_bvalid_o", word_t'(s_bvalid_o), 32'd1);
            expect_equal("s_bresp_o", word_t'(s_bresp_o), word_t'(resp));
            expect_equal("s_awready_o", word_t'(s_awready_o), 32'd0);
            expect_equal("s_wready_o", word_t'(s_wready_o), 32'd0);
        end
        s_bready_i = 1'b1;
        tick();
        s_bready_i = 1'b0;
    endtask

    task automatic axil_write(input axil_addr_t addr, input word_t data,
                              input logic [3:0] strb, output logic [1:0] resp);
        drive_write(addr, data, strb);
        await_write_accept();
        collect_response(0, resp);
    endtask

    task automatic axil_read(input axil_addr_t addr, output word_t data);
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        while (!s_arready_o) tick();
        tick();
        s_arvalid_i = 1'b0;
        while (!s_rvalid_o) tick();
        data = s_rdata_o;
        expect_equal("s_rresp_o", word_t'(s_rresp_o), word_t'(OKAY));
        s_rready_i = 1'b1;
        tick();
        s_rready_i = 1'b0;
    endtask

    task automatic check_reg(input reg_idx_t idx);
        word_t data;
        axil_read({1'b1, idx, 2'b00}, data);
        expect_equal($sformatf("s_rdata_o x%0d", idx), data, model_regs[idx]);
    endtask

    task automatic check_state();
        word_t data;
        axil_read(ADDR_PC, data);
        expect_equal("s_rdata_o pc", data, model_pc);
        axil_read(ADDR_RETIRE, data);
        expect_equal("s_rdata_o retire count", data, word_t'(model_retire));
    endtask

    initial begin
        word_t      instr;
        word_t      instr2;
        word_t      data;
        logic [1:0] resp;
        logic [1:0] exp_resp;
        logic [1:0] exp_resp2;
        int         hold;
        reset_i     = 1'b1;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        model_pc     = RESET_PC;
        model_retire = '0;
        repeat (5) @(posedge clk);
        #2;
        reset_i = 1'b0;
        tick();

        // Reset state
        check_state();
        for (int i = 0; i < 32; i++) check_reg(reg_idx_t'(i));

        // Random integer stream
        for (int i = 0; i < N_ALU; i++) begin
            random_alu_instr(instr);
            model_step(instr, exp_resp);
            axil_write(ADDR_CMD, instr, 4'hF, resp);
            expect_equal("s_bresp_o", word_t'(resp), word_t'(exp_resp));
            check_reg(instr[11:7]);
            check_reg(5'd0);
        end

        // LUI and AUIPC in turn
        for (int i = 0; i < 8; i++) begin
            data  = rand_word();
            instr = {data[31:12], data[11:7], (i % 2 == 0) ? 7'h37 : 7'h17};
            model_step(instr, exp_resp);
            axil_write(ADDR_CMD, instr, 4'hF, resp);
            expect_equal("s_bresp_o", word_t'(resp), word_t'(exp_resp));
            check_reg(instr[11:7]);
            check_state();
            axil_read(ADDR_CMD, data);
            expect_equal("s_rdata_o command", data, instr);
        end

        // Unsupported and undefined words aimed at x5
        for (int i = 0; i < 6; i++) begin
            data  = rand_word();
            instr = {data[31:12], 5'd5, BAD_OPS[i]};
            model_step(instr, exp_resp);
            axil_write(ADDR_CMD, instr, 4'hF, resp);
            expect_equal("s_bresp_o", word_t'(resp), word_t'(exp_resp));
            check_state();
            check_reg(5'd5);
        end

        // Held-off bready with a second write waiting
        for (int i = 0; i < 8; i++) begin
            random_alu_instr(instr);
            random_alu_instr(instr2);
            hold = int'(rand_word() % 8) + 1;
            model_step(instr, exp_resp);
            model_step(instr2, exp_resp2);
            drive_write(ADDR_CMD, instr, 4'hF);
            await_write_accept();
            drive_write(ADDR_CMD, instr2, 4'hF);
            collect_response(hold, resp);
            expect_equal("s_bresp_o", word_t'(resp), word_t'(exp_resp));
            await_write_accept();
            collect_response(0, resp);
            expect_equal("s_bresp_o", word_t'(resp), word_t'(exp_resp2));
            check_reg(instr[11:7]);
            check_reg(instr2[11:7]);
        end

        // Partial strobe on the command register
        random_alu_instr(instr);
        axil_write(ADDR_CMD, instr, 4'h3, resp);
        expect_equal("s_bresp_o", word_t'(resp), word_t'(SLVERR));
        check_state();

        if (dut.u_host.u_sva.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "%0d concurrent assertion failures", dut.u_host.u_sva.fail_count);
        end
    end

endmodule

// ==== verilog.f ====
hdl/rv_exec_pkg.sv
hdl/decode_if.sv
hdl/issue_if.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/exec_datapath.sv
hdl/axil_host_regs.sv
hdl/rv_exec_top.sv
bench/rv_exec_sva.sv
bench/rv_exec_tb.sv
